//--- hdl/pad_mux_pkg.sv
// ------------------
// Pad mux shared types
// ------------------

`default_nettype none

package pad_mux_pkg;

  // Bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = 4;

  localparam int unsigned NumPadsDefault = 4;

  // Pad i select register lives at BaseAddr + 4*i
  localparam logic [AddrWidth-1:0] BaseAddr = 32'h2000_0000;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // Pad index width, kept at least one bit wide
  function automatic int unsigned idx_width(input int unsigned num_pads);
    return (num_pads > 1) ? $clog2(num_pads) : 1;
  endfunction

endpackage

`default_nettype wire

//--- hdl/pad_cfg_if.sv
// ------------------
// Pad config write port
// ------------------

`timescale 1ns/1ps
`default_nettype none

interface pad_cfg_if #(
  parameter int unsigned NumPads = pad_mux_pkg::NumPadsDefault
) ();

  localparam int unsigned IdxWidth = pad_mux_pkg::idx_width(NumPads);

  logic                wr_en;
  logic [IdxWidth-1:0] wr_idx;
  logic                wr_sel;
  // Address missed the pad range
  logic                wr_err;

  modport source (output wr_en, output wr_idx, output wr_sel, output wr_err);

  modport sink (input wr_en, input wr_idx, input wr_sel, input wr_err);

endinterface

`default_nettype wire

//--- hdl/rst_sync.sv
// ------------------
// Reset synchronizer
// ------------------

`timescale 1ns/1ps
`default_nettype none

module rst_sync (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic rst_sync_n_o
);

  logic stage1_q;
  logic stage2_q;

  // Assert at once, release after two edges
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage1_q <= 1'b0;
      stage2_q <= 1'b0;
    end else begin
      stage1_q <= 1'b1;
      stage2_q <= stage1_q;
    end
  end

  assign rst_sync_n_o = stage2_q;

endmodule

`default_nettype wire

//--- hdl/pad_bus_frontend.sv
// ------------------
// Bus request front end
// ------------------

`timescale 1ns/1ps
`default_nettype none

module pad_bus_frontend #(
  parameter int unsigned NumPads = pad_mux_pkg::NumPadsDefault
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  logic               we_i,
  input  pad_mux_pkg::be_t   be_i,
  input  pad_mux_pkg::addr_t addr_i,
  input  pad_mux_pkg::data_t wdata_i,
  output logic               gnt_o,
  pad_cfg_if.source          cfg
);

  localparam int unsigned IdxWidth = pad_mux_pkg::idx_width(NumPads);

  pad_mux_pkg::addr_t offset;
  pad_mux_pkg::addr_t word_idx;
  logic               in_range;
  logic               wr_accept;

  // Grant every request once out of reset
  assign gnt_o = req_i & rst_n_i;

  // Address decode
  assign offset   = addr_i - pad_mux_pkg::BaseAddr;
  assign word_idx = offset >> 2;
  assign in_range = (addr_i >= pad_mux_pkg::BaseAddr) &&
                    (offset[1:0] == 2'b00) &&
                    (word_idx < pad_mux_pkg::addr_t'(NumPads));

  // Only byte lane 0 carries the select bit
  assign wr_accept = req_i & gnt_o & we_i & be_i[0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg.wr_en <= 1'b0;
    end else begin
      cfg.wr_en <= wr_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      cfg.wr_idx <= word_idx[IdxWidth-1:0];
      cfg.wr_sel <= wdata_i[0];
      cfg.wr_err <= ~in_range;
    end
  end

  // A granted request must carry a known command for the decode
  a_gnt_needs_req : assert property (
    @(posedge clk_i)
    gnt_o |-> (req_i && !$isunknown({we_i, be_i[0], addr_i}))
  ) else $error("gnt_o high without a known request");

endmodule

`default_nettype wire

//--- hdl/pad_ctrl_regs.sv
// ------------------
// Pad select registers
// ------------------

`timescale 1ns/1ps
`default_nettype none

module pad_ctrl_regs #(
  parameter int unsigned NumPads = pad_mux_pkg::NumPadsDefault
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  pad_cfg_if.sink            cfg,
  output logic [NumPads-1:0] pad_sel_o
);

  logic [NumPads-1:0] sel_q;
  logic               wr_valid;

  // Front end already flagged out of range writes
  assign wr_valid = cfg.wr_en & ~cfg.wr_err;

  // All pads start on the primary function
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= '0;
    end else if (wr_valid) begin
      sel_q[cfg.wr_idx] <= cfg.wr_sel;
    end
  end

  assign pad_sel_o = sel_q;

  // Decode in the front end must keep the index inside the bank
  a_idx_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (cfg.wr_en && !cfg.wr_err) |-> (int'(cfg.wr_idx) < NumPads)
  ) else $error("write index %0d beyond pad count", cfg.wr_idx);

endmodule

`default_nettype wire

//--- hdl/pad_mux.sv
// ------------------
// Shared pad mux
// ------------------

`timescale 1ns/1ps
`default_nettype none

module pad_mux #(
  parameter int unsigned NumPads = pad_mux_pkg::NumPadsDefault
) (
  input  logic [NumPads-1:0] pad_sel_i,
  input  logic [NumPads-1:0] pri_out_i,
  input  logic [NumPads-1:0] pri_oe_i,
  input  logic [NumPads-1:0] alt_out_i,
  input  logic [NumPads-1:0] alt_oe_i,
  input  logic [NumPads-1:0] pad_in_i,
  output logic [NumPads-1:0] pad_out_o,
  output logic [NumPads-1:0] pad_oe_o,
  output logic [NumPads-1:0] pri_in_o,
  output logic [NumPads-1:0] alt_in_o
);

  always_comb begin
    // Unselected function sees zero
    pri_in_o = '0;
    alt_in_o = '0;
    for (int i = 0; i < NumPads; i++) begin
      if (pad_sel_i[i]) begin
        pad_out_o[i] = alt_out_i[i];
        pad_oe_o[i]  = alt_oe_i[i];
        alt_in_o[i]  = pad_in_i[i];
      end else begin
        pad_out_o[i] = pri_out_i[i];
        pad_oe_o[i]  = pri_oe_i[i];
        pri_in_o[i]  = pad_in_i[i];
      end
    end
  end

  // An unknown select would drive both functions ambiguously
  always_comb begin
    a_sel_known : assert (!$isunknown(pad_sel_i))
      else $error("pad_sel_i is unknown");
  end

endmodule

`default_nettype wire

//--- hdl/pad_mux_top.sv
// ------------------
// Pad mux control top
// ------------------

`timescale 1ns/1ps
`default_nettype none

module pad_mux_top #(
  parameter int unsigned NumPads = pad_mux_pkg::NumPadsDefault
) (
  input  logic               clk_i,
  input  logic               rst_n_i,

  // Bridge request port
  input  logic               req_i,
  input  logic               we_i,
  input  pad_mux_pkg::be_t   be_i,
  input  pad_mux_pkg::addr_t addr_i,
  input  pad_mux_pkg::data_t wdata_i,
  output logic               gnt_o,

  // Function side
  input  logic [NumPads-1:0] pri_out_i,
  input  logic [NumPads-1:0] pri_oe_i,
  input  logic [NumPads-1:0] alt_out_i,
  input  logic [NumPads-1:0] alt_oe_i,
  output logic [NumPads-1:0] pri_in_o,
  output logic [NumPads-1:0] alt_in_o,

  // Pad side
  input  logic [NumPads-1:0] pad_in_i,
  output logic [NumPads-1:0] pad_out_o,
  output logic [NumPads-1:0] pad_oe_o
);

  logic               rst_sync_n;
  logic [NumPads-1:0] pad_sel;

  pad_cfg_if #(.NumPads(NumPads)) u_cfg_if ();

  // --------------------
  // Reset and bus
  // --------------------
  rst_sync u_rst_sync (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rst_sync_n_o(rst_sync_n)
  );

  pad_bus_frontend #(
    .NumPads(NumPads)
  ) u_pad_bus_frontend (
    .clk_i  (clk_i),
    .rst_n_i(rst_sync_n),
    .req_i  (req_i),
    .we_i   (we_i),
    .be_i   (be_i),
    .addr_i (addr_i),
    .wdata_i(wdata_i),
    .gnt_o  (gnt_o),
    .cfg    (u_cfg_if.source)
  );

  // --------------------
  // Selects and pads
  // --------------------
  pad_ctrl_regs #(
    .NumPads(NumPads)
  ) u_pad_ctrl_regs (
    .clk_i    (clk_i),
    .rst_n_i  (rst_sync_n),
    .cfg      (u_cfg_if.sink),
    .pad_sel_o(pad_sel)
  );

  pad_mux #(
    .NumPads(NumPads)
  ) u_pad_mux (
    .pad_sel_i(pad_sel),
    .pri_out_i(pri_out_i),
    .pri_oe_i (pri_oe_i),
    .alt_out_i(alt_out_i),
    .alt_oe_i (alt_oe_i),
    .pad_in_i (pad_in_i),
    .pad_out_o(pad_out_o),
    .pad_oe_o (pad_oe_o),
    .pri_in_o (pri_in_o),
    .alt_in_o (alt_in_o)
  );

endmodule

`default_nettype wire

//--- sim/pad_mux_tb.sv
// --------------------
// Pad mux testbench
// --------------------

`timescale 1ns/1ps
`default_nettype none

module pad_mux_tb;

  localparam int unsigned NumPads      = pad_mux_pkg::NumPadsDefault;
  localparam int unsigned ResetCycles  = 5;
  localparam int unsigned SettleCycles = 3;
  localparam int unsigned CyclesPerLine = 20;

  typedef logic [NumPads-1:0] pad_vec_t;

  logic               clk_i;
  logic               rst_n_i;
  logic               req_i;
  logic               we_i;
  pad_mux_pkg::be_t   be_i;
  pad_mux_pkg::addr_t addr_i;
  pad_mux_pkg::data_t wdata_i;
  logic               gnt_o;
  pad_vec_t           pri_out_i;
  pad_vec_t           pri_oe_i;
  pad_vec_t           alt_out_i;
  pad_vec_t           alt_oe_i;
  pad_vec_t           pri_in_o;
  pad_vec_t           alt_in_o;
  pad_vec_t           pad_in_i;
  pad_vec_t           pad_out_o;
  pad_vec_t           pad_oe_o;

  // Parsed steps, one entry per step
  string              kind_q[$];
  string              name_q[$];
  logic               we_q[$];
  pad_mux_pkg::be_t   be_q[$];
  pad_mux_pkg::addr_t addr_q[$];
  pad_mux_pkg::data_t wdata_q[$];
  logic               gnt_q[$];
  pad_vec_t           sel_q[$];

  int unsigned watchdog_cycles = 0;

  pad_mux_top #(
    .NumPads(NumPads)
  ) u_pad_mux_top (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (req_i),
    .we_i     (we_i),
    .be_i     (be_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .gnt_o    (gnt_o),
    .pri_out_i(pri_out_i),
    .pri_oe_i (pri_oe_i),
    .alt_out_i(alt_out_i),
    .alt_oe_i (alt_oe_i),
    .pri_in_o (pri_in_o),
    .alt_in_o (alt_in_o),
    .pad_in_i (pad_in_i),
    .pad_out_o(pad_out_o),
    .pad_oe_o (pad_oe_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic stop_on_error();
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic load_tests(output int unsigned line_count);
    int    fd;
    int    n;
    string line;
    string kind;
    string name;
    logic               we;
    pad_mux_pkg::be_t   be;
    pad_mux_pkg::addr_t addr;
    pad_mux_pkg::data_t wdata;
    logic               gnt;
    pad_vec_t           sel;
    line_count = 0;
    fd = $fopen("sim/pad_mux_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test file sim/pad_mux_tests.txt");
      stop_on_error();
    end
    while ($fgets(line, fd) != 0) begin
      line_count++;
      n = $sscanf(line, "%s", kind);
      if (n < 1 || kind.substr(0, 0) == "#") continue;
      if (kind == "W") begin
        n = $sscanf(line, "%s %s %h %h %h %h %h", kind, name, we, be, addr, wdata, gnt);
        if (n != 7) begin
          $display("Malformed write step on line %0d of the test file", line_count);
          stop_on_error();
        end
        sel = '0;
      end else if (kind == "C") begin
        n = $sscanf(line, "%s %s %h", kind, name, sel);
        if (n != 3) begin
          $display("Malformed check step on line %0d of the test file", line_count);
          stop_on_error();
        end
        we    = 1'b0;
        be    = '0;
        addr  = '0;
        wdata = '0;
        gnt   = 1'b0;
      end else begin
        $display("Unknown step kind %s on line %0d of the test file", kind, line_count);
        stop_on_error();
      end
      kind_q.push_back(kind);
      name_q.push_back(name);
      we_q.push_back(we);
      be_q.push_back(be);
      addr_q.push_back(addr);
      wdata_q.push_back(wdata);
      gnt_q.push_back(gnt);
      sel_q.push_back(sel);
    end
    $fclose(fd);
  endtask

  task automatic compare_vec(input string name, input string what,
                             input pad_vec_t expected, input pad_vec_t actual);
    assert (actual === expected) else begin
      $display("FAIL %s: %s expected %h, actual %h", name, what, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic compare_gnt(input string name, input logic expected);
    assert (gnt_o === expected) else begin
      $display("FAIL %s: gnt_o expected %0b, actual %0b", name, expected, gnt_o);
      stop_on_error();
    end
  endtask

  // One bus request per cycle, grant checked before the accepting edge
  task automatic run_write(input int k);
    @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = we_q[k];
    be_i    = be_q[k];
    addr_i  = addr_q[k];
    wdata_i = wdata_q[k];
    #1;
    compare_gnt(name_q[k], gnt_q[k]);
  endtask

  task automatic run_check(input int k);
    pad_vec_t sel;
    pad_vec_t exp_out;
    pad_vec_t exp_oe;
    pad_vec_t exp_pri_in;
    pad_vec_t exp_alt_in;
    sel = sel_q[k];
    @(negedge clk_i);
    req_i   = 1'b0;
    we_i    = 1'b0;
    be_i    = '0;
    addr_i  = '0;
    wdata_i = '0;
    #1;
    compare_gnt(name_q[k], 1'b0);
    // Let the last write reach the pads
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    pri_out_i = pad_vec_t'($urandom());
    pri_oe_i  = pad_vec_t'($urandom());
    alt_out_i = pad_vec_t'($urandom());
    alt_oe_i  = pad_vec_t'($urandom());
    pad_in_i  = pad_vec_t'($urandom());
    #2;
    // Select 1 picks the alternate function
    exp_out    = (sel & alt_out_i) | (~sel & pri_out_i);
    exp_oe     = (sel & alt_oe_i) | (~sel & pri_oe_i);
    exp_pri_in = ~sel & pad_in_i;
    exp_alt_in = sel & pad_in_i;
    compare_vec(name_q[k], "pad_out_o", exp_out, pad_out_o);
    compare_vec(name_q[k], "pad_oe_o", exp_oe, pad_oe_o);
    compare_vec(name_q[k], "pri_in_o", exp_pri_in, pri_in_o);
    compare_vec(name_q[k], "alt_in_o", exp_alt_in, alt_in_o);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int unsigned line_count;
    void'($urandom(39639));
    rst_n_i   = 1'b0;
    req_i     = 1'b0;
    we_i      = 1'b0;
    be_i      = '0;
    addr_i    = '0;
    wdata_i   = '0;
    pri_out_i = '0;
    pri_oe_i  = '0;
    alt_out_i = '0;
    alt_oe_i  = '0;
    pad_in_i  = '0;

    load_tests(line_count);
    watchdog_cycles = CyclesPerLine * line_count + ResetCycles + SettleCycles;

    // Requests during reset must not be granted
    repeat (ResetCycles) begin
      @(negedge clk_i);
      req_i = 1'b1;
      #1;
      compare_gnt("reset_hold", 1'b0);
    end
    @(negedge clk_i);
    rst_n_i = 1'b1;
    req_i   = 1'b0;
    repeat (SettleCycles) @(posedge clk_i);

    for (int k = 0; k < kind_q.size(); k++) begin
      if (kind_q[k] == "W") begin
        run_write(k);
      end else begin
        run_check(k);
      end
    end

    @(negedge clk_i);
    req_i = 1'b0;
    $display("No errors");
    $finish;
  end

  initial begin : watchdog
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("Watchdog timeout, run did not finish in %0d cycles", watchdog_cycles);
    $display("Errors found");
    $fatal(1, "Simulation stopped by the watchdog");
  end

endmodule

`default_nettype wire

//--- sim/pad_mux_tests.txt
# W name we be addr wdata gnt   (bus write or read request, hex fields)
# C name sel                    (expected select vector, bit i = pad i, 1 = alternate)
C reset_default 0
W wr_pad0_alt 1 1 20000000 00000001 1
C pad0_alt 1
W wr_pad0_pri 1 1 20000000 00000000 1
C pad0_restored 0
W wr_pad2_alt 1 1 20000008 00000001 1
C pad2_alt 4
W wr_pad2_be_clear 1 e 20000008 00000000 1
W rd_pad2 0 f 20000008 00000000 1
W rd_pad1 0 1 20000004 00000001 1
C pad2_kept 4
W wr_beyond_last 1 1 20000010 00000001 1
W wr_far_beyond 1 f 20000100 ffffffff 1
W wr_unaligned 1 1 20000001 00000001 1
W wr_unaligned_hi 1 1 2000000e 00000001 1
W wr_below_base 1 1 1ffffffc 00000001 1
C ignored_writes 4
W b2b_pad0 1 1 20000000 00000001 1
W b2b_pad1 1 f 20000004 00000001 1
W b2b_pad3 1 1 2000000c ffffffff 1
W b2b_pad2_off 1 1 20000008 00000002 1
C b2b_all b
W clr_pad1 1 1 20000004 00000000 1
W clr_pad3 1 3 2000000c 00000000 1
C after_clear 1
W set_pad3 1 1 2000000c 00000001 1
W clr_pad0 1 1 20000000 fffffffe 1
C final_sel 8

//--- pad_mux_ctrl.f
hdl/pad_mux_pkg.sv
hdl/pad_cfg_if.sv
hdl/rst_sync.sv
hdl/pad_bus_frontend.sv
hdl/pad_ctrl_regs.sv
hdl/pad_mux.sv
hdl/pad_mux_top.sv
sim/pad_mux_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := pad_mux_tb
FILELIST  := pad_mux_ctrl.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := No errors
FAIL_MSG  := Errors found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
